// ==== memGolden.txt ====
// Columns are address word, data, ack expected, expected ack data, burst flag
// Hex words with bus bit 0 leftmost, burst 1 means no idle gap before the line
// Memory writes, reads and write-test
040000010 123456789 1 000000000 0
040000011 FEDCBA987 1 000000000 0
0400000FF 555555555 1 000000000 0
100000010 000000000 1 123456789 0
100000011 000000000 1 FEDCBA987 0
0800000FF 000000000 1 555555555 0
1000000FF 000000000 1 555555555 0
// Nonexistent memory and the MSR flag
100000100 000000000 1 000000000 0
10A008000 000000000 1 800000000 0
04A008000 800000000 1 000000000 0
10A008000 000000000 1 000000000 0
0403FFFFF 111111111 1 000000000 0
10A008000 000000000 1 800000000 0
// MSR scratch field
04A008000 8FFE2ABCD 1 000000000 0
10A008000 000000000 1 00002ABCD 0
04A008000 000013579 1 000000000 0
10A008000 000000000 1 000013579 0
// Requests with no acknowledge
10A048000 000000000 0 000000000 0
10A008001 000000000 0 000000000 0
102008000 000000000 0 000000000 0
000000010 000000000 0 000000000 0
100000010 000000000 1 123456789 0
04A008001 FFFFFFFFF 0 000000000 0
10A008000 000000000 1 000013579 0
// Back to back burst
040000020 0A0A0A0A0 1 000000000 1
040000021 0B0B0B0B0 1 000000000 1
040000022 0C0C0C0C0 1 000000000 1
100000020 000000000 1 0A0A0A0A0 1
100000021 000000000 1 0B0B0B0B0 1
040000020 777777777 1 000000000 1
100000020 000000000 1 777777777 1
100000022 000000000 1 0C0C0C0C0 1
080000011 000000000 1 FEDCBA987 1
10A008000 000000000 1 000013579 1
100000100 000000000 1 000000000 1
10A008000 000000000 1 800013579 1

// ==== project.f ====
+incdir+.
ks10Pkg.sv
busRequester.sv
requestFifo.sv
memStatus.sv
ssramArray.sv
memController.sv
memSubsystem.sv
memSubsystemTb.sv

// ==== memSubsystemTb.sv ====
//////////////////////////////
// Memory subsystem testbench
// Replays golden bus requests and checks
// the acknowledges in request order
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ks10_cfg.svh"

module memSubsystemTb
   import ks10Pkg::*;
   ();

   localparam int clkPERIOD   = 100;   // ns
   localparam int resetCYCLES = 8;
   localparam int goldenLINES = 36;    // Requests in memGolden.txt
   localparam int goldenCOLS  = 5;     // addr, data, ack, ack data, burst

   logic                 cpuCLK;
   logic                 rst;
   logic                 reqValid;
   busAddrWord           reqAddr;
   logic [0:`busWIDTH-1] reqData;
   logic                 reqReady;
   logic                 ackValid;
   logic [0:`busWIDTH-1] ackData;

   logic [`busWIDTH-1:0] goldenMem [goldenLINES*goldenCOLS];
   logic [`busWIDTH-1:0] expQ [$];      // Ack data still owed
   logic [7:0]           lfsr;          // Gap generator state
   int                   ackCount;
   int                   expectTotal;

   memSubsystem memSubsystem_inst
   (
      .cpuCLK   (cpuCLK),
      .rst      (rst),
      .reqValid (reqValid),
      .reqAddr  (reqAddr),
      .reqData  (reqData),
      .reqReady (reqReady),
      .ackValid (ackValid),
      .ackData  (ackData)
   );

   always #(clkPERIOD/2) cpuCLK = ~cpuCLK;

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Galois LFSR with polynomial x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsrNext(input logic [7:0] state);
      logic [7:0] next;
      next = state >> 1;
      if (state[0])
         next = next ^ 8'hB8;   // Feedback taps
      return next;
   endfunction

   task automatic stopOnError(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic checkValue(input string name, input logic [`busWIDTH-1:0] actual,
                             input logic [`busWIDTH-1:0] expected);
      if (actual !== expected)
         stopOnError($sformatf("FAILED at %0d ns: %s is %h, expected %h",
                               $time, name, actual, expected));
   endtask

   // Two LFSR bits give 0..3 idle cycles
   task automatic pickGap(output int gap);
      logic lo;
      logic hi;
      lo   = lfsr[0];
      lfsr = lfsrNext(lfsr);
      hi   = lfsr[0];
      lfsr = lfsrNext(lfsr);
      gap  = {hi, lo};
   endtask

   // Hold the request until an edge with reqReady high
   task automatic sendRequest(input logic [`busWIDTH-1:0] addr, input logic [`busWIDTH-1:0] data,
                              input logic expectAck, input logic [`busWIDTH-1:0] expData);
      logic taken;
      reqValid = 1'b1;
      reqAddr  = addr;
      reqData  = data;
      taken    = 1'b0;
      while (!taken)
      begin
         @(negedge cpuCLK);
         taken = reqReady;      // Registered so steady until the edge
         @(posedge cpuCLK);
         #5;
      end
      if (expectAck)
         expQ.push_back(expData);
      reqValid = 1'b0;
   endtask

   //////////////////////////////
   // Ack monitor
   //////////////////////////////

   always @(negedge cpuCLK)
   begin
      if (!rst && ackValid === 1'b1)
      begin
         if (expQ.size() == 0)
            stopOnError("An acknowledge arrived with no request waiting for one");
         else
         begin
            ackCount++;
            checkValue("ackData", ackData, expQ.pop_front());
         end
      end
   end

   // Watchdog sized from the golden file
   initial
   begin
      #((goldenLINES * 20 + resetCYCLES) * clkPERIOD);
      stopOnError("Timeout: the run did not finish within the watchdog time");
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial
   begin
      int base;
      int gap;
      int waitCycles;
      cpuCLK      = 1'b0;
      rst         = 1'b1;
      reqValid    = 1'b0;
      reqAddr     = '0;
      reqData     = '0;
      lfsr        = 8'd4;       // Seed
      ackCount    = 0;
      expectTotal = 0;

      $readmemh("memGolden.txt", goldenMem);
      for (int i = 0; i < goldenLINES * goldenCOLS; i++)
      begin
         if ($isunknown(goldenMem[i]))
            stopOnError("The golden file is short or holds a bad entry");
      end
      for (int n = 0; n < goldenLINES; n++)
         expectTotal += goldenMem[n*goldenCOLS + 2][0];

      // Reset with outputs quiet throughout
      repeat (resetCYCLES) @(posedge cpuCLK);
      #5;
      checkValue("ackValid", ackValid, '0);
      checkValue("reqReady", reqReady, '0);
      rst = 1'b0;

      waitCycles = 0;
      while (reqReady !== 1'b1)
      begin
         if (waitCycles == 4)
            stopOnError("reqReady did not rise after reset");
         @(posedge cpuCLK);
         #5;
         waitCycles++;
      end

      for (int n = 0; n < goldenLINES; n++)
      begin
         base = n * goldenCOLS;
         if (goldenMem[base+4] == 0)     // Burst lines go back to back
         begin
            pickGap(gap);
            repeat (gap)
            begin
               @(posedge cpuCLK);
               #5;
            end
         end
         sendRequest(goldenMem[base], goldenMem[base+1], goldenMem[base+2][0],
                     goldenMem[base+3]);
      end

      // Drain the queue and watch a few cycles for strays
      while (expQ.size() != 0)
         @(posedge cpuCLK);
      repeat (8) @(posedge cpuCLK);

      if (ackCount != expectTotal)
         stopOnError($sformatf("Got %0d acknowledges but the golden file expects %0d",
                               ackCount, expectTotal));
      else
      begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== memSubsystem.sv ====
//////////////////////////////
// KS-10 memory subsystem
// Requester, queue, controller, MSR and store
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ks10_cfg.svh"

module memSubsystem
   import ks10Pkg::*;
   (
      input  logic                 cpuCLK,     // Clock
      input  logic                 rst,        // Reset
      input  logic                 reqValid,   // Bus request
      input  busAddrWord           reqAddr,    // Request address word
      input  logic [0:`busWIDTH-1] reqData,    // Request data
      output logic                 reqReady,   // Request taken
      output logic                 ackValid,   // Acknowledge
      output logic [0:`busWIDTH-1] ackData     // Acknowledge data
   );

   localparam int addrBits = $clog2(`memWORDS);

   // Requester to queue
   logic                 pushValid;
   busAddrWord           pushAddr;
   logic [0:`busWIDTH-1] pushData;
   logic                 creditReturn;

   // Queue to controller
   logic                 headValid;
   busAddrWord           headAddr;
   logic [0:`busWIDTH-1] headData;
   logic                 pop;

   // Controller to store and MSR
   logic                 ramWrite;
   logic [0:addrBits-1]  ramAddr;
   logic [0:`busWIDTH-1] ramWriteData;
   logic [0:`busWIDTH-1] ramReadData;
   logic                 msrWrite;
   logic [0:`busWIDTH-1] msrWriteData;
   logic                 nxmSet;
   logic [0:`busWIDTH-1] regStat;

   busRequester busRequester_inst
   (
      .cpuCLK       (cpuCLK),
      .rst          (rst),
      .reqValid     (reqValid),
      .reqAddr      (reqAddr),
      .reqData      (reqData),
      .reqReady     (reqReady),
      .pushValid    (pushValid),
      .pushAddr     (pushAddr),
      .pushData     (pushData),
      .creditReturn (creditReturn)
   );

   requestFifo requestFifo_inst
   (
      .cpuCLK       (cpuCLK),
      .rst          (rst),
      .pushValid    (pushValid),
      .pushAddr     (pushAddr),
      .pushData     (pushData),
      .headValid    (headValid),
      .headAddr     (headAddr),
      .headData     (headData),
      .pop          (pop),
      .creditReturn (creditReturn)
   );

   memController #(.addrBits(addrBits)) memController_inst
   (
      .cpuCLK       (cpuCLK),
      .rst          (rst),
      .headValid    (headValid),
      .headAddr     (headAddr),
      .headData     (headData),
      .pop          (pop),
      .ramWrite     (ramWrite),
      .ramAddr      (ramAddr),
      .ramWriteData (ramWriteData),
      .ramReadData  (ramReadData),
      .msrWrite     (msrWrite),
      .msrWriteData (msrWriteData),
      .nxmSet       (nxmSet),
      .regStat      (regStat),
      .ackValid     (ackValid),
      .ackData      (ackData)
   );

   memStatus memStatus_inst
   (
      .cpuCLK       (cpuCLK),
      .rst          (rst),
      .msrWrite     (msrWrite),
      .msrWriteData (msrWriteData),
      .nxmSet       (nxmSet),
      .regStat      (regStat)
   );

   ssramArray #(.addrBits(addrBits)) ssramArray_inst
   (
      .cpuCLK       (cpuCLK),
      .ramWrite     (ramWrite),
      .ramAddr      (ramAddr),
      .ramWriteData (ramWriteData),
      .ramReadData  (ramReadData)
   );

endmodule

`default_nettype wire

// ==== memController.sv ====
//////////////////////////////
// Memory controller
// Decodes queued bus requests, runs the array
// or MSR access and returns acknowledges
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ks10_cfg.svh"

module memController
   import ks10Pkg::*;
   #(
      parameter int addrBits = $clog2(`memWORDS)   // Array address width
   )
   (
      input  logic                 cpuCLK,        // Clock
      input  logic                 rst,           // Reset
      input  logic                 headValid,     // Queue not empty
      input  busAddrWord           headAddr,      // Queued address word
      input  logic [0:`busWIDTH-1] headData,      // Queued data
      output logic                 pop,           // Take queue head
      output logic                 ramWrite,      // Array write enable
      output logic [0:addrBits-1]  ramAddr,       // Array word address
      output logic [0:`busWIDTH-1] ramWriteData,  // Array write data
      input  logic [0:`busWIDTH-1] ramReadData,   // Array read data
      output logic                 msrWrite,      // MSR write cycle
      output logic [0:`busWIDTH-1] msrWriteData,  // MSR write data
      output logic                 nxmSet,        // Flag NXM in MSR
      input  logic [0:`busWIDTH-1] regStat,       // MSR contents
      output logic                 ackValid,      // Acknowledge
      output logic [0:`busWIDTH-1] ackData        // Acknowledge data
   );

   // Flags, common to both views
   logic busRead;
   logic busWrTest;
   logic busWrite;
   logic busPhys;
   logic busIo;

   // Decode terms
   logic devMatch;
   logic addrMatch;
   logic inRange;
   logic memRead;
   logic memWrTest;
   logic memWrite;
   logic memAny;
   logic msrRead;
   logic msrWriteReq;

   // Stage 1 state
   logic s1Valid;      // Acknowledge owed
   logic s1RamRd;      // Data from array
   logic s1MsrRd;      // Data from MSR
   logic s1Nxm;        // Nonexistent memory

   //////////////////////////////
   // Stage 1 decode
   //////////////////////////////

   assign busRead   = headAddr.memView.flags[`flagREAD];
   assign busWrTest = headAddr.memView.flags[`flagWRTEST];
   assign busWrite  = headAddr.memView.flags[`flagWRITE];
   assign busPhys   = headAddr.ioView.flags[`flagPHYS];
   assign busIo     = headAddr.ioView.flags[`flagIO];

   assign devMatch  = (headAddr.ioView.dev == `memDEV);        // We are device 0
   assign addrMatch = (headAddr.ioView.ioAddr == `addrMSR);
   assign inRange   = (headAddr.memView.memAddr < `memWORDS);  // Above is NXM

   // Memory cycles, write-test reads like a read
   assign memRead   = busRead & !busIo;
   assign memWrTest = busWrTest & !busIo;
   assign memWrite  = busWrite & !busIo;
   assign memAny    = memRead | memWrTest | memWrite;

   // MSR needs physical IO to our device and register
   assign msrRead     = busRead & busIo & busPhys & devMatch & addrMatch;
   assign msrWriteReq = busWrite & busIo & busPhys & devMatch & addrMatch;

   assign pop = headValid;   // One entry per cycle, never stalls

   // Array and MSR accesses go out in the pop cycle
   assign ramWrite     = pop & memWrite & inRange;
   assign ramAddr      = headAddr.memView.memAddr[`busWIDTH-addrBits:`busWIDTH-1];
   assign ramWriteData = headData;
   assign msrWrite     = pop & msrWriteReq;
   assign msrWriteData = headData;

   always_ff @(posedge cpuCLK)
   begin
      if (rst)
      begin
         s1Valid <= 1'b0;
         s1RamRd <= 1'b0;
         s1MsrRd <= 1'b0;
         s1Nxm   <= 1'b0;
      end
      else
      begin
         s1Valid <= pop & (memAny | msrRead | msrWriteReq);   // Unmatched drops out
         s1RamRd <= pop & (memRead | memWrTest) & inRange;
         s1MsrRd <= pop & msrRead;
         s1Nxm   <= pop & memAny & !inRange;
      end
   end

   //////////////////////////////
   // Stage 2 acknowledge
   //////////////////////////////

   assign nxmSet = s1Nxm;   // MSR flag lands with the ack

   always_ff @(posedge cpuCLK)
   begin
      if (rst)
         ackValid <= 1'b0;
      else
         ackValid <= s1Valid;
   end

   // Writes and NXM acknowledge with zero
   always_ff @(posedge cpuCLK)
   begin
      if (s1RamRd)
         ackData <= ramReadData;
      else if (s1MsrRd)
         ackData <= regStat;
      else
         ackData <= '0;
   end

endmodule

`default_nettype wire

// ==== ssramArray.sv ====
//////////////////////////////
// Word store
// Single port synchronous array, registered read
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ks10_cfg.svh"

module ssramArray
   #(
      parameter int addrBits = $clog2(`memWORDS)   // Word address width
   )
   (
      input  logic                 cpuCLK,        // Clock
      input  logic                 ramWrite,      // Write enable
      input  logic [0:addrBits-1]  ramAddr,       // Word address
      input  logic [0:`busWIDTH-1] ramWriteData,  // Write data
      output logic [0:`busWIDTH-1] ramReadData    // Read data, one cycle late
   );

   logic [0:`busWIDTH-1] mem [`memWORDS];   // Contents undefined until written

   //////////////////////////////
   // Array port
   //////////////////////////////

   // Read returns the old word on a same-cycle write
   always_ff @(posedge cpuCLK)
   begin
      if (ramWrite)
         mem[ramAddr] <= ramWriteData;
      ramReadData <= mem[ramAddr];
   end

endmodule

`default_nettype wire

// ==== memStatus.sv ====
//////////////////////////////
// Memory Status Register
// NXM flag plus a writable scratch field
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ks10_cfg.svh"

module memStatus
   (
      input  logic                 cpuCLK,        // Clock
      input  logic                 rst,           // Reset
      input  logic                 msrWrite,      // MSR write cycle
      input  logic [0:`busWIDTH-1] msrWriteData,  // MSR write data
      input  logic                 nxmSet,        // Nonexistent memory seen
      output logic [0:`busWIDTH-1] regStat        // MSR read data
   );

   logic         regNxm;       // Bit 0
   logic [18:35] regScratch;   // Bits 18..35

   // NXM flag, hardware set beats software clear
   always_ff @(posedge cpuCLK)
   begin
      if (rst)
         regNxm <= 1'b0;
      else if (nxmSet)
         regNxm <= 1'b1;
      else if (msrWrite & msrWriteData[0])
         regNxm <= 1'b0;                // Write one to clear
   end

   // Scratch field, whole field replaced per write
   always_ff @(posedge cpuCLK)
   begin
      if (rst)
         regScratch <= '0;
      else if (msrWrite)
         regScratch <= msrWriteData[18:35];
   end

   // Unused bits read as zero
   assign regStat = {regNxm, 17'b0, regScratch};

endmodule

`default_nettype wire

// ==== requestFifo.sv ====
//////////////////////////////
// Request queue
// Circular buffer of bus requests, one credit
// back to the requester per entry popped
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ks10_cfg.svh"

module requestFifo
   import ks10Pkg::*;
   (
      input  logic                 cpuCLK,        // Clock
      input  logic                 rst,           // Reset
      input  logic                 pushValid,     // Write strobe
      input  busAddrWord           pushAddr,      // Address word in
      input  logic [0:`busWIDTH-1] pushData,      // Data in
      output logic                 headValid,     // Oldest entry present
      output busAddrWord           headAddr,      // Oldest address word
      output logic [0:`busWIDTH-1] headData,      // Oldest data
      input  logic                 pop,           // Consumer takes head
      output logic                 creditReturn   // Slot freed last cycle
   );

   localparam int ptrBits = $clog2(`fifoDEPTH);
   localparam int cntBits = $clog2(`fifoDEPTH + 1);

   busAddrWord           addrMem [`fifoDEPTH];   // Address words
   logic [0:`busWIDTH-1] dataMem [`fifoDEPTH];   // Matching data words
   logic [ptrBits-1:0]   wrPtr;
   logic [ptrBits-1:0]   rdPtr;
   logic [cntBits-1:0]   count;                   // Occupancy
   logic                 doPop;

   // Wraps at depth, which need not be a power of two
   function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
      if (ptr == ptrBits'(`fifoDEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign headValid = (count != '0);
   assign headAddr  = addrMem[rdPtr];
   assign headData  = dataMem[rdPtr];
   assign doPop     = pop & headValid;   // Ignore pop on empty

   // Entry storage written on each push
   always_ff @(posedge cpuCLK)
   begin
      if (pushValid)
      begin
         addrMem[wrPtr] <= pushAddr;
         dataMem[wrPtr] <= pushData;
      end
   end

   //////////////////////////////
   // Pointers and occupancy
   //////////////////////////////

   always_ff @(posedge cpuCLK)
   begin
      if (rst)
      begin
         wrPtr        <= '0;
         rdPtr        <= '0;
         count        <= '0;
         creditReturn <= 1'b0;
      end
      else
      begin
         if (pushValid)
            wrPtr <= nextPtr(wrPtr);
         if (doPop)
            rdPtr <= nextPtr(rdPtr);
         case ({pushValid, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // Idle or push with pop
         endcase
         creditReturn <= doPop;             // One credit per entry out
      end
   end

endmodule

`default_nettype wire

// ==== busRequester.sv ====
//////////////////////////////
// Bus requester
// Takes bus requests and pushes them into the
// request queue while holding credits
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ks10_cfg.svh"

module busRequester
   import ks10Pkg::*;
   (
      input  logic                 cpuCLK,        // Clock
      input  logic                 rst,           // Reset
      input  logic                 reqValid,      // Request present
      input  busAddrWord           reqAddr,       // Request address word
      input  logic [0:`busWIDTH-1] reqData,       // Request data
      output logic                 reqReady,      // Request taken
      output logic                 pushValid,     // Queue write strobe
      output busAddrWord           pushAddr,      // Queue address word
      output logic [0:`busWIDTH-1] pushData,      // Queue data
      input  logic                 creditReturn   // Queue slot freed
   );

   localparam int creditBits = $clog2(`fifoDEPTH + 1);

   logic [creditBits-1:0] credits;    // Free queue slots we may use
   logic [creditBits-1:0] creditNext;
   logic                  take;

   assign take = reqValid & reqReady;       // Handshake on this edge

   //////////////////////////////
   // Credit counter
   //////////////////////////////

   // Spend on take, earn on return, both cancel
   always_comb
   begin
      creditNext = credits;
      if (take & !creditReturn)
         creditNext = credits - 1'b1;
      else if (!take & creditReturn)
         creditNext = credits + 1'b1;
   end

   always_ff @(posedge cpuCLK)
   begin
      if (rst)
      begin
         credits   <= creditBits'(`fifoDEPTH);   // Queue starts empty
         reqReady  <= 1'b0;
         pushValid <= 1'b0;
      end
      else
      begin
         credits   <= creditNext;
         reqReady  <= (creditNext != '0);       // Ready while a slot is left
         pushValid <= take;                     // One push per request
      end
   end

   // Request payload held for the push cycle
   always_ff @(posedge cpuCLK)
   begin
      if (take)
      begin
         pushAddr <= reqAddr;
         pushData <= reqData;
      end
   end

endmodule

`default_nettype wire

// ==== ks10Pkg.sv ====
//////////////////////////////
// KS-10 bus types
// Address word as memory or IO reference
//////////////////////////////

`default_nettype none

package ks10Pkg;

   //////////////////////////////
   // Memory reference layout
   //////////////////////////////

   typedef struct packed
   {
      logic [ 0:13] flags;       // Cycle flags
      logic [14:35] memAddr;     // Word address
   } busMemView;

   //////////////////////////////
   // IO reference layout
   //////////////////////////////

   typedef struct packed
   {
      logic [ 0:13] flags;       // Same flags as memory view
      logic [14:17] dev;         // Device number, 0 is memory
      logic [18:35] ioAddr;      // Register address in device
   } busIoView;

   // Address phase word, decoded either way by the controller
   typedef union packed
   {
      busMemView memView;
      busIoView  ioView;
   } busAddrWord;

endpackage

`default_nettype wire

// ==== ks10_cfg.svh ====
//////////////////////////////
// KS-10 memory subsystem config
// Bus layout, store size, MSR decode and queue depth
//////////////////////////////

`ifndef KS10_CFG_SVH
`define KS10_CFG_SVH

// Bus word, bits numbered 0 (MSB) to 35
`define busWIDTH    36

// Cycle flags, positions within bits 0..13
`define flagREAD    3           // Read cycle
`define flagWRTEST  4           // Write-test cycle
`define flagWRITE   5           // Write cycle
`define flagPHYS    8           // Physical reference
`define flagIO      10          // IO reference

// Word store
`define memWORDS    256         // Words implemented, higher is NXM

// Memory controller as an IO device
`define memDEV      4'd0        // Device 0 on the backplane
`define addrMSR     18'o100000  // Memory Status Register

// Request queue depth, also the initial credit count
`define fifoDEPTH   4

`endif
